// ==== rtl/cube_defs.svh ====
/* LED cube sizes */

`ifndef CUBE_DEFS_SVH
`define CUBE_DEFS_SVH

// number of per-channel line memories
`define CUBE_CHAN_NUM 16

// word address width of one channel memory
`define CUBE_RAM_AW   8

// configuration registers
`define CUBE_REG_NUM  8

`endif

// ==== rtl/cube_pkg.sv ====
/* LED cube shared types */

`include "cube_defs.svh"

package cube_pkg;

    typedef enum logic [7:0] {
        CONF_WR = 8'h2a,
        ADDR_WR = 8'h2b,
        DATA_WR = 8'h2c,
        INFO_RD = 8'h3a
    } cmd_t;

    typedef struct packed {
        logic       vld;    // one cycle per completed byte
        logic       dc;     // low for a command byte
        logic [7:0] data;
    } spi_byte_t;

    typedef struct packed {
        logic                              en;
        logic [$clog2(`CUBE_REG_NUM)-1:0] addr;
        logic [7:0]                        data;
    } reg_wr_t;

    typedef struct packed {
        logic [`CUBE_CHAN_NUM-1:0] chan_en;    // one-hot target channel
        logic [`CUBE_RAM_AW-1:0]   addr;
        logic [3:0]                byte_en;
        logic [7:0]                data;
        logic                      done;       // last byte of the frame
    } ram_wr_t;

    // lane 3 scan address, lane 2 red, lane 1 green, lane 0 blue
    typedef logic [3:0][7:0] cube_word_t;

endpackage

// ==== rtl/spi_byte_rx.sv ====
/* SPI byte receiver */

`timescale 1ns/1ps

module spi_byte_rx (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 spi_sclk_i,
    input  logic                 spi_mosi_i,
    input  logic                 spi_cs_n_i,
    input  logic                 spi_dc_i,

    input  logic [7:0]           tx_byte_i,

    output cube_pkg::spi_byte_t  rx_byte_o,
    output logic                 spi_miso_o
);

logic [2:0] sclk_sync;
logic [2:0] cs_n_sync;
logic [1:0] mosi_sync;
logic [1:0] dc_sync;

logic [2:0] bit_cnt;
logic [7:0] rx_shift;
logic [7:0] tx_shift;

logic       byte_vld;
logic       tx_load;
logic       byte_dc;
logic [7:0] byte_data;

wire sclk_rise = sclk_sync[1] & ~sclk_sync[2];
wire sclk_fall = ~sclk_sync[1] & sclk_sync[2];
wire cs_fall   = ~cs_n_sync[1] & cs_n_sync[2];
wire cs_act    = ~cs_n_sync[1];

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        sclk_sync <= 3'b000;
        cs_n_sync <= 3'b111;
        mosi_sync <= 2'b00;
        dc_sync   <= 2'b00;
        bit_cnt   <= 3'd0;
        byte_vld  <= 1'b0;
        tx_load   <= 1'b0;
        tx_shift  <= 8'h00;
    end else begin
        sclk_sync <= {sclk_sync[1:0], spi_sclk_i};
        cs_n_sync <= {cs_n_sync[1:0], spi_cs_n_i};
        mosi_sync <= {mosi_sync[0], spi_mosi_i};
        dc_sync   <= {dc_sync[0], spi_dc_i};

        byte_vld <= 1'b0;
        tx_load  <= byte_vld;    // register read address settles one cycle after the strobe

        if (!cs_act) begin
            bit_cnt <= 3'd0;
        end else if (sclk_rise) begin
            bit_cnt  <= bit_cnt + 3'd1;
            byte_vld <= (bit_cnt == 3'd7);
        end

        if (cs_fall || tx_load) begin
            tx_shift <= tx_byte_i;
        end else if (cs_act && sclk_fall && bit_cnt != 3'd0) begin
            tx_shift <= {tx_shift[6:0], 1'b0};    // the falling edge closing a byte keeps the new MSB
        end
    end
end

always_ff @(posedge clk_i) begin
    if (cs_act && sclk_rise) begin
        rx_shift <= {rx_shift[6:0], mosi_sync[1]};
        if (bit_cnt == 3'd7) begin
            byte_data <= {rx_shift[6:0], mosi_sync[1]};
            byte_dc   <= dc_sync[1];
        end
    end
end

assign rx_byte_o.vld  = byte_vld;
assign rx_byte_o.dc   = byte_dc;
assign rx_byte_o.data = byte_data;

assign spi_miso_o = tx_shift[7];

endmodule

// ==== rtl/channel_ctl.sv ====
/* Command decoder and write sequencer */

`timescale 1ns/1ps

`include "cube_defs.svh"

module channel_ctl (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  cube_pkg::spi_byte_t rx_byte_i,

    input  logic [7:0]          chan_len_i,
    input  logic [3:0]          chan_cnt_i,

    output logic [2:0]          reg_rd_addr_o,
    output cube_pkg::reg_wr_t   reg_wr_o,
    output cube_pkg::ram_wr_t   ram_wr_o
);

logic [2:0] rd_addr;
logic [7:0] wr_addr;

logic       addr_en;    // scan-address lane active
logic [2:0] data_en;    // colour lane rotation, red first
logic       info_rd;
logic       conf_wr;
logic [`CUBE_CHAN_NUM-1:0] data_wr;    // one-hot current channel

logic       cmd_stb;
logic       wr_stb;
logic       addr_wrap;
logic       data_wrap;
logic       chan_wrap;
logic       last_chan;
logic [3:0] byte_en;

////////////////////////////////////////
// write strobes

assign cmd_stb   = rx_byte_i.vld & ~rx_byte_i.dc;
assign wr_stb    = rx_byte_i.vld & rx_byte_i.dc;
assign addr_wrap = addr_en & (wr_addr == chan_len_i);
assign data_wrap = data_en[0] & (wr_addr == chan_len_i);
assign chan_wrap = addr_wrap | data_wrap;
assign last_chan = data_wr[chan_cnt_i];
assign byte_en   = {addr_en, data_en};

assign reg_rd_addr_o = rd_addr;

always_comb begin
    reg_wr_o.en   = conf_wr & wr_stb;
    reg_wr_o.addr = wr_addr[2:0];
    reg_wr_o.data = rx_byte_i.data;

    ram_wr_o.chan_en = data_wr & {`CUBE_CHAN_NUM{wr_stb & (|byte_en)}};
    ram_wr_o.addr    = wr_addr;
    ram_wr_o.byte_en = byte_en;
    ram_wr_o.data    = rx_byte_i.data;
    ram_wr_o.done    = wr_stb & last_chan & chan_wrap;
end

////////////////////////////////////////
// sequencer

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        rd_addr <= 3'd0;
        wr_addr <= 8'h00;
        addr_en <= 1'b0;
        data_en <= 3'b000;
        info_rd <= 1'b0;
        conf_wr <= 1'b0;
        data_wr <= '0;
    end else if (cmd_stb) begin
        rd_addr <= 3'd0;
        wr_addr <= 8'h00;
        addr_en <= 1'b0;    // unknown codes leave every mode off
        data_en <= 3'b000;
        info_rd <= 1'b0;
        conf_wr <= 1'b0;
        data_wr <= '0;

        case (cube_pkg::cmd_t'(rx_byte_i.data))
            cube_pkg::CONF_WR: conf_wr <= 1'b1;
            cube_pkg::ADDR_WR: begin
                addr_en <= 1'b1;
                data_wr <= `CUBE_CHAN_NUM'(1);
            end
            cube_pkg::DATA_WR: begin
                data_en <= 3'b100;
                data_wr <= `CUBE_CHAN_NUM'(1);
            end
            cube_pkg::INFO_RD: info_rd <= 1'b1;
            default: ;
        endcase
    end else if (wr_stb) begin
        if (info_rd) begin
            rd_addr <= rd_addr + 3'd1;
        end

        if (chan_wrap) begin
            wr_addr <= 8'h00;
            data_wr <= data_wr << 1;
        end else if (conf_wr || addr_en || data_en[0]) begin
            wr_addr <= wr_addr + 8'd1;    // colour bytes advance only after blue
        end

        addr_en <= addr_en & ~(addr_wrap & last_chan);
        data_en <= {data_en[0], data_en[2:1]};
    end
end

endmodule

// ==== rtl/conf_regfile.sv ====
/* Configuration registers */

`timescale 1ns/1ps

`include "cube_defs.svh"

module conf_regfile (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  cube_pkg::reg_wr_t reg_wr_i,

    input  logic [2:0]        rd_addr_i,
    output logic [7:0]        rd_data_o,

    output logic [7:0]        chan_len_o,
    output logic [3:0]        chan_cnt_o
);

logic [7:0] regs [`CUBE_REG_NUM];

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        for (int i = 0; i < `CUBE_REG_NUM; i++) begin
            regs[i] <= 8'h00;
        end
    end else if (reg_wr_i.en) begin
        regs[reg_wr_i.addr] <= reg_wr_i.data;
    end
end

assign rd_data_o = regs[rd_addr_i];

// last word index of every channel
assign chan_len_o = regs[0];

// index of the last channel in a frame
assign chan_cnt_o = regs[1][3:0];

endmodule

// ==== rtl/chan_ram_bank.sv ====
/* Channel line memories */

`timescale 1ns/1ps

`include "cube_defs.svh"

module chan_ram_bank #(
    parameter int DEPTH = 2 ** `CUBE_RAM_AW
) (
    input  logic                 clk_i,

    input  cube_pkg::ram_wr_t    ram_wr_i,

    input  logic [3:0]           rd_chan_i,
    input  logic [7:0]           rd_addr_i,
    output cube_pkg::cube_word_t rd_data_o
);

localparam int AW = $clog2(DEPTH);

cube_pkg::cube_word_t rd_word [`CUBE_CHAN_NUM];

for (genvar c = 0; c < `CUBE_CHAN_NUM; c++) begin : g_chan
    cube_pkg::cube_word_t mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (ram_wr_i.chan_en[c]) begin
            for (int l = 0; l < 4; l++) begin
                if (ram_wr_i.byte_en[l]) begin
                    mem[ram_wr_i.addr[AW-1:0]][l] <= ram_wr_i.data;
                end
            end
        end
    end

    assign rd_word[c] = mem[rd_addr_i[AW-1:0]];
end

always_ff @(posedge clk_i) begin
    rd_data_o <= rd_word[rd_chan_i];    // display port sees the word one cycle later
end

endmodule

// ==== rtl/cube_spi_top.sv ====
/* LED cube SPI front end */

`timescale 1ns/1ps

module cube_spi_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 spi_sclk_i,
    input  logic                 spi_mosi_i,
    input  logic                 spi_cs_n_i,
    input  logic                 spi_dc_i,
    output logic                 spi_miso_o,

    input  logic [3:0]           ram_rd_chan_i,
    input  logic [7:0]           ram_rd_addr_i,
    output cube_pkg::cube_word_t ram_rd_data_o,

    output logic [7:0]           chan_len_o,
    output logic [3:0]           chan_cnt_o,
    output logic                 frame_done_o
);

cube_pkg::spi_byte_t rx_byte;
cube_pkg::reg_wr_t   reg_wr;
cube_pkg::ram_wr_t   ram_wr;

logic [2:0] reg_rd_addr;
logic [7:0] reg_rd_data;

spi_byte_rx u_spi_byte_rx (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .spi_sclk_i (spi_sclk_i),
    .spi_mosi_i (spi_mosi_i),
    .spi_cs_n_i (spi_cs_n_i),
    .spi_dc_i   (spi_dc_i),
    .tx_byte_i  (reg_rd_data),
    .rx_byte_o  (rx_byte),
    .spi_miso_o (spi_miso_o)
);

channel_ctl u_channel_ctl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .rx_byte_i     (rx_byte),
    .chan_len_i    (chan_len_o),
    .chan_cnt_i    (chan_cnt_o),
    .reg_rd_addr_o (reg_rd_addr),
    .reg_wr_o      (reg_wr),
    .ram_wr_o      (ram_wr)
);

conf_regfile u_conf_regfile (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .reg_wr_i   (reg_wr),
    .rd_addr_i  (reg_rd_addr),
    .rd_data_o  (reg_rd_data),
    .chan_len_o (chan_len_o),
    .chan_cnt_o (chan_cnt_o)
);

chan_ram_bank u_chan_ram_bank (
    .clk_i     (clk_i),
    .ram_wr_i  (ram_wr),
    .rd_chan_i (ram_rd_chan_i),
    .rd_addr_i (ram_rd_addr_i),
    .rd_data_o (ram_rd_data_o)
);

assign frame_done_o = ram_wr.done;

endmodule

// ==== testbench/tb_clkgen.sv ====
/* Testbench clock and reset */

`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
end

always #50 clk_o = ~clk_o;    // 100 ns period

endmodule

// ==== testbench/cube_spi_properties.sv ====
/* Sequencer write checks */

`timescale 1ns/1ps

module cube_spi_properties (
    input logic              clk_i,
    input logic              rst_n_i,
    input cube_pkg::reg_wr_t reg_wr_i,
    input cube_pkg::ram_wr_t ram_wr_i
);

int fail_cnt = 0;

chan_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(ram_wr_i.chan_en))
    else begin fail_cnt++; $error("channel enable has more than one bit set"); end

wr_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(reg_wr_i.en && (|ram_wr_i.chan_en)))
    else begin fail_cnt++; $error("register and memory write in the same cycle"); end

lane_split: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ram_wr_i.byte_en[3] && (|ram_wr_i.byte_en[2:0])))
    else begin fail_cnt++; $error("scan address lane mixed with colour lanes"); end

// nothing may be written while the block is held in reset
reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> (!reg_wr_i.en && ram_wr_i.chan_en == '0 && !ram_wr_i.done))
    else begin fail_cnt++; $error("write enable active during reset"); end

endmodule

bind channel_ctl cube_spi_properties u_props (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .reg_wr_i (reg_wr_o),
    .ram_wr_i (ram_wr_o)
);

// ==== testbench/cube_spi_tb.sv ====
/* LED cube SPI front end testbench */

`timescale 1ns/1ps

`include "cube_defs.svh"

module cube_spi_tb;

localparam int N_ENTRIES  = 10;
localparam int BYTE_LIMIT = 200;    // cycles allowed per byte of the table
localparam int DEPTH      = 2 ** `CUBE_RAM_AW;

typedef logic [7:0] byte_q_t [$];

logic                 clk;
logic                 rst_n;
logic                 spi_sclk;
logic                 spi_mosi;
logic                 spi_cs_n;
logic                 spi_dc;
logic                 spi_miso;
logic [3:0]           ram_rd_chan;
logic [7:0]           ram_rd_addr;
cube_pkg::cube_word_t ram_rd_data;
logic [7:0]           chan_len;
logic [3:0]           chan_cnt;
logic                 frame_done;

string      tbl_name [N_ENTRIES];
logic [7:0] tbl_cmd  [N_ENTRIES];
int         tbl_len  [N_ENTRIES];    // fixed data bytes
int         tbl_mult [N_ENTRIES];    // plus this many whole frames
int         tbl_done [N_ENTRIES];

logic [7:0]           cfg      [`CUBE_REG_NUM];
logic [7:0]           exp_regs [`CUBE_REG_NUM];
cube_pkg::cube_word_t exp_mem  [`CUBE_CHAN_NUM][DEPTH];
logic [3:0]           exp_vld  [`CUBE_CHAN_NUM][DEPTH];    // lanes known so far

int word_errs  = 0;
int byte_errs  = 0;
int pulse_errs = 0;
int done_total = 0;
int cycles     = 0;
int cycle_limit;

tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

cube_spi_top u_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .spi_sclk_i    (spi_sclk),
    .spi_mosi_i    (spi_mosi),
    .spi_cs_n_i    (spi_cs_n),
    .spi_dc_i      (spi_dc),
    .spi_miso_o    (spi_miso),
    .ram_rd_chan_i (ram_rd_chan),
    .ram_rd_addr_i (ram_rd_addr),
    .ram_rd_data_o (ram_rd_data),
    .chan_len_o    (chan_len),
    .chan_cnt_o    (chan_cnt),
    .frame_done_o  (frame_done)
);

always @(negedge clk) begin
    if (frame_done === 1'b1) begin
        done_total++;
    end
end

always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
        $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("FAIL: see errors above");
        $finish;
    end
end

////////////////////////////////////////
// compare tasks

task automatic check_word(input string name, input cube_pkg::cube_word_t exp,
                          input cube_pkg::cube_word_t act);
    if (act !== exp) begin
        word_errs++;
        $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        byte_errs++;
        $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_pulse(input string name, input int exp, input int act);
    if (act != exp) begin
        pulse_errs++;
        $display("** Error %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

////////////////////////////////////////
// SPI host, mode 0 at 4 clocks per half period

task automatic shift_byte(input logic dc, input logic [7:0] tx, output logic [7:0] rx);
    spi_dc = dc;
    for (int b = 7; b >= 0; b--) begin
        spi_mosi = tx[b];
        repeat (4) @(negedge clk);
        rx[b]    = spi_miso;    // host samples just before the rising edge
        spi_sclk = 1'b1;
        repeat (4) @(negedge clk);
        spi_sclk = 1'b0;
    end
    repeat (8) @(negedge clk);
endtask

task automatic send_transaction(input logic [7:0] cmd, input byte_q_t tx, output byte_q_t rx);
    logic [7:0] rx_byte;

    rx       = {};
    spi_cs_n = 1'b0;
    repeat (4) @(negedge clk);
    shift_byte(1'b0, cmd, rx_byte);
    foreach (tx[i]) begin
        shift_byte(1'b1, tx[i], rx_byte);
        rx.push_back(rx_byte);
    end
    spi_cs_n = 1'b1;
    repeat (4) @(negedge clk);
endtask

////////////////////////////////////////
// expected state

function automatic int frame_bytes(input logic [7:0] len, input logic [3:0] cnt);
    return (int'(len) + 1) * (int'(cnt) + 1);
endfunction

task automatic update_model(input logic [7:0] cmd, input byte_q_t tx);
    int words;
    int frame;
    int w;

    words = int'(exp_regs[0]) + 1;
    frame = frame_bytes(exp_regs[0], exp_regs[1][3:0]);
    foreach (tx[i]) begin
        w = i / 3;
        if (cmd == cube_pkg::CONF_WR && i < `CUBE_REG_NUM) begin
            exp_regs[i] = tx[i];
        end else if (cmd == cube_pkg::ADDR_WR && i < frame) begin
            exp_mem[i / words][i % words][3] = tx[i];    // channel c word a is byte c*(L+1)+a
            exp_vld[i / words][i % words][3] = 1'b1;
        end else if (cmd == cube_pkg::DATA_WR && i < 3 * frame) begin
            exp_mem[w / words][w % words][2 - i % 3] = tx[i];    // red, green, blue per word
            exp_vld[w / words][w % words][2 - i % 3] = 1'b1;
        end
    end
endtask

task automatic check_memory(input string name);
    cube_pkg::cube_word_t exp;
    cube_pkg::cube_word_t act;

    for (int c = 0; c < `CUBE_CHAN_NUM; c++) begin
        for (int a = 0; a < DEPTH; a++) begin
            if (exp_vld[c][a] != 4'h0) begin
                ram_rd_chan = 4'(c);
                ram_rd_addr = 8'(a);
                @(negedge clk);
                act = ram_rd_data;
                exp = exp_mem[c][a];
                for (int l = 0; l < 4; l++) begin
                    if (!exp_vld[c][a][l]) begin
                        exp[l] = 8'h00;
                        act[l] = 8'h00;
                    end
                end
                check_word($sformatf("%s chan %0d word %0d", name, c, a), exp, act);
            end
        end
    end
endtask

task automatic add_entry(input int idx, input string name, input logic [7:0] cmd,
                         input int len, input int mult, input int done);
    tbl_name[idx] = name;
    tbl_cmd[idx]  = cmd;
    tbl_len[idx]  = len;
    tbl_mult[idx] = mult;
    tbl_done[idx] = done;
endtask

////////////////////////////////////////
// main sequence

initial begin
    byte_q_t tx;
    byte_q_t rx;
    int      total;
    int      done_start;

    spi_sclk    = 1'b0;
    spi_mosi    = 1'b0;
    spi_cs_n    = 1'b1;
    spi_dc      = 1'b0;
    ram_rd_chan = 4'h0;
    ram_rd_addr = 8'h00;

    void'($urandom(32'hc3235eb4));
    for (int i = 0; i < `CUBE_REG_NUM; i++) begin
        cfg[i]      = 8'($urandom);
        exp_regs[i] = 8'h00;
    end
    cfg[0] = {6'd0, cfg[0][1:0]} + 8'd3;           // 4 to 7 words per channel
    cfg[1] = {cfg[1][7:4], 2'b00, cfg[1][1:0]};    // upper nibble is outside the count
    for (int c = 0; c < `CUBE_CHAN_NUM; c++) begin
        for (int a = 0; a < DEPTH; a++) begin
            exp_vld[c][a] = 4'h0;
        end
    end

    add_entry(0, "conf_wide",    cube_pkg::CONF_WR, 2, 0, 0);
    add_entry(1, "addr_fill",    cube_pkg::ADDR_WR, 0, 1, 1);
    add_entry(2, "conf_write",   cube_pkg::CONF_WR, 8, 0, 0);
    add_entry(3, "info_read",    cube_pkg::INFO_RD, 8, 0, 0);
    add_entry(4, "addr_write",   cube_pkg::ADDR_WR, 4, 1, 1);    // four bytes past the frame
    add_entry(5, "data_write",   cube_pkg::DATA_WR, 0, 3, 1);
    add_entry(6, "unknown_cmd",  8'h55,             6, 0, 0);
    add_entry(7, "info_reread",  cube_pkg::INFO_RD, 8, 0, 0);
    add_entry(8, "addr_partial", cube_pkg::ADDR_WR, 3, 0, 0);
    add_entry(9, "addr_restart", cube_pkg::ADDR_WR, 1, 0, 0);

    total = 0;
    for (int e = 0; e < N_ENTRIES; e++) begin
        total += 1 + tbl_len[e] + tbl_mult[e] * frame_bytes(cfg[0], cfg[1][3:0]);
    end
    cycle_limit = total * BYTE_LIMIT;

    @(posedge rst_n);
    @(negedge clk);

    for (int e = 0; e < N_ENTRIES; e++) begin
        tx = {};
        repeat (tbl_len[e] + tbl_mult[e] * frame_bytes(exp_regs[0], exp_regs[1][3:0])) begin
            tx.push_back(8'($urandom));
        end
        if (tbl_cmd[e] == cube_pkg::CONF_WR) begin
            foreach (tx[i]) begin
                tx[i] = cfg[i];
            end
            if (tx.size() < `CUBE_REG_NUM) begin
                tx[1] = cfg[1] + 8'd1;    // one extra channel so that overrun bytes hit known words
            end
        end

        done_start = done_total;
        send_transaction(tbl_cmd[e], tx, rx);
        update_model(tbl_cmd[e], tx);

        if (tbl_cmd[e] == cube_pkg::INFO_RD) begin
            for (int k = 0; k < rx.size() && k < `CUBE_REG_NUM; k++) begin
                check_byte($sformatf("%s miso byte %0d", tbl_name[e], k), exp_regs[k], rx[k]);
            end
        end
        check_pulse({tbl_name[e], " frame_done"}, tbl_done[e], done_total - done_start);
        check_byte({tbl_name[e], " chan_len"}, exp_regs[0], chan_len);
        check_byte({tbl_name[e], " chan_cnt"}, {4'h0, exp_regs[1][3:0]}, {4'h0, chan_cnt});
        check_memory(tbl_name[e]);
    end

    $display("errors: word %0d, byte %0d, pulse %0d, assertion %0d",
             word_errs, byte_errs, pulse_errs, u_dut.u_channel_ctl.u_props.fail_cnt);
    if (word_errs + byte_errs + pulse_errs + u_dut.u_channel_ctl.u_props.fail_cnt == 0) begin
        $display("PASS: all tests");
    end else begin
        $display("FAIL: see errors above");
    end
    $finish;
end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/cube_pkg.sv
rtl/spi_byte_rx.sv
rtl/channel_ctl.sv
rtl/conf_regfile.sv
rtl/chan_ram_bank.sv
rtl/cube_spi_top.sv
testbench/tb_clkgen.sv
testbench/cube_spi_properties.sv
testbench/cube_spi_tb.sv

// ==== Makefile ====
# Verilator simulation of the LED cube SPI front end

VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= cube_spi_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
